//--- rtl/cpuTypesPkg.sv
// Shared types for a MIPS-like subset; no shifts, link jumps or exceptions are encoded
package cpuTypesPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regBits_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluOp_t;

  typedef struct packed {
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   aluSrcImm;  // Operand B from immediate
    logic   zeroExt;
    logic   branch;
    logic   bne;        // Invert branch compare
    logic   jump;
    logic   halt;
    aluOp_t aluOp;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
  } ifId_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    pc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regBits_t dest;
    word_t    jumpTarget;
  } idEx_t;

  typedef struct packed {
    logic     valid;
    regBits_t dest;
    word_t    data;
  } wb_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } memReq_t;

endpackage

//--- rtl/pipeRegIfId.sv
// Flush wins over enable; only valid and instr are cleared, pc keeps its last value
`timescale 1ns/1ps

module pipeRegIfId
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  enable,
  input  logic  flush,
  input  ifId_t ifIdIn,
  output ifId_t ifIdOut
);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      ifIdOut.valid <= 1'b0;
      ifIdOut.instr <= '0;
    end
    else if (flush)
    begin
      // Wrong-path slot becomes a bubble
      ifIdOut.valid <= 1'b0;
      ifIdOut.instr <= '0;
    end
    else if (enable)
    begin
      ifIdOut.valid <= ifIdIn.valid;
      ifIdOut.instr <= ifIdIn.instr;
      ifIdOut.pc    <= ifIdIn.pc;
    end
  end

endmodule

//--- rtl/fetchUnit.sv
// Memory must return rdata in the ready cycle; a fetch caught by a redirect completes and is dropped
`timescale 1ns/1ps

module fetchUnit
  import cpuTypesPkg::*;
#(
  parameter word_t RESET_PC = '0
)
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      halted,
  input  logic      slotFree,
  input  redirect_t redirect,
  output logic      iReqValid,
  output word_t     iReqAddr,
  input  logic      iReqReady,
  input  word_t     iRdata,
  output ifId_t     fetched
);

  word_t pc;
  word_t redirPc;
  logic  fetchEn;
  logic  reqPending;
  logic  drop;
  logic  slotOpen;
  logic  fire;

  assign slotOpen  = !fetched.valid || slotFree;  // Slot empty or drained this cycle
  assign iReqValid = reqPending || (fetchEn && !halted && !redirect.valid && slotOpen);
  assign iReqAddr  = pc;
  assign fire      = iReqValid && iReqReady;

  // Target held while a stale fetch finishes
  always_ff @(posedge CLK)
  begin
    if (redirect.valid)
      redirPc <= redirect.target;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      pc         <= RESET_PC;
      fetchEn    <= 1'b0;
      reqPending <= 1'b0;
      drop       <= 1'b0;
      fetched    <= '0;
    end
    else
    begin
      fetchEn    <= 1'b1;
      reqPending <= iReqValid && !iReqReady;  // Keeps the request up until its handshake

      if (fire && drop)
      begin
        pc   <= redirPc;
        drop <= 1'b0;
      end
      else if (redirect.valid && iReqValid && !iReqReady)
        drop <= 1'b1;  // Address must stay put, so retarget later
      else if (redirect.valid)
        pc <= redirect.target;
      else if (fire)
        pc <= pc + 32'd4;

      if (redirect.valid)
        fetched.valid <= 1'b0;
      else if (fire && !drop)
      begin
        fetched.valid <= 1'b1;
        fetched.instr <= iRdata;
        fetched.pc    <= pc;
      end
      else if (slotFree)
        fetched.valid <= 1'b0;
    end
  end

endmodule

//--- rtl/decodeStage.sv
// No forwarding; a source that matches the writer in execute stalls until its write edge
`timescale 1ns/1ps

module decodeStage
  import cpuTypesPkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  ifId_t     ifId,
  input  wb_t       wb,
  input  logic      exStall,
  input  redirect_t redirect,
  input  regBits_t  exDest,
  input  logic      exWrites,
  output logic      takeIn,
  output idEx_t     idEx
);

  word_t    regFile [32];
  opcode_t  opcode;
  funct_t   funct;
  regBits_t rs;
  regBits_t rt;
  regBits_t rd;
  ctrl_t    ctrl;
  word_t    imm;
  word_t    pcPlus4;
  word_t    rdat1;
  word_t    rdat2;
  logic     usesRs;
  logic     usesRt;
  logic     hazard;

  assign opcode  = opcode_t'(ifId.instr[31:26]);
  assign funct   = funct_t'(ifId.instr[5:0]);
  assign rs      = ifId.instr[25:21];
  assign rt      = ifId.instr[20:16];
  assign rd      = ifId.instr[15:11];
  assign pcPlus4 = ifId.pc + 32'd4;

  always_comb
  begin
    ctrl = '0;
    case (opcode)
      OP_RTYPE:
      begin
        ctrl.regWrite = 1'b1;
        case (funct)
          FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:  ctrl.aluOp = ALU_AND;
          FN_OR:   ctrl.aluOp = ALU_OR;
          FN_SLT:  ctrl.aluOp = ALU_SLT;
          default: ctrl.regWrite = 1'b0;  // Unknown funct is a NOP
        endcase
      end
      OP_ADDIU:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      OP_ORI:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.zeroExt   = 1'b1;
        ctrl.aluOp     = ALU_OR;
      end
      OP_LUI:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.zeroExt   = 1'b1;
        ctrl.aluOp     = ALU_LUI;
      end
      OP_LW:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      OP_SW:
      begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      OP_BEQ:  ctrl.branch = 1'b1;
      OP_BNE:
      begin
        ctrl.branch = 1'b1;
        ctrl.bne    = 1'b1;
      end
      OP_J:    ctrl.jump = 1'b1;
      OP_HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

  assign imm = ctrl.zeroExt ? {16'h0, ifId.instr[15:0]} : {{16{ifId.instr[15]}}, ifId.instr[15:0]};

  // Register zero is hardwired
  assign rdat1 = (rs == '0) ? '0 : regFile[rs];
  assign rdat2 = (rt == '0) ? '0 : regFile[rt];

  always_ff @(posedge CLK)
  begin
    if (wb.valid && wb.dest != '0)
      regFile[wb.dest] <= wb.data;
  end

  assign usesRs = !(opcode inside {OP_J, OP_LUI, OP_HALT});
  assign usesRt = opcode inside {OP_RTYPE, OP_SW, OP_BEQ, OP_BNE};
  assign hazard = ifId.valid && exWrites && (exDest != '0)
                  && ((usesRs && rs == exDest) || (usesRt && rt == exDest));
  assign takeIn = !exStall && !hazard;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      idEx <= '0;
    else if (!exStall)
    begin
      if (redirect.valid || hazard)
      begin
        idEx.valid <= 1'b0;  // Bubble
        idEx.ctrl  <= '0;
      end
      else
        idEx <= '{valid: ifId.valid, ctrl: ctrl, pc: ifId.pc, rdat1: rdat1, rdat2: rdat2,
                  imm: imm, dest: (opcode == OP_RTYPE) ? rd : rt,
                  jumpTarget: {pcPlus4[31:28], ifId.instr[25:0], 2'b00}};
    end
  end

endmodule

//--- rtl/executeStage.sv
// Retires one instruction per cycle unless a load/store waits; nothing issues after HALT
`timescale 1ns/1ps

module executeStage
  import cpuTypesPkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  idEx_t     idEx,
  output logic      exStall,
  output regBits_t  exDest,
  output logic      exWrites,
  output redirect_t redirect,
  output wb_t       wb,
  output logic      dReqValid,
  output memReq_t   dReq,
  input  logic      dReqReady,
  input  word_t     dRdata,
  output logic      halted
);

  word_t aluB;
  word_t aluRes;
  word_t branchTarget;
  logic  active;
  logic  isMem;
  logic  taken;

  assign active = idEx.valid && !halted;
  assign aluB   = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.rdat2;

  always_comb
  begin
    case (idEx.ctrl.aluOp)
      ALU_ADD: aluRes = idEx.rdat1 + aluB;
      ALU_SUB: aluRes = idEx.rdat1 - aluB;
      ALU_AND: aluRes = idEx.rdat1 & aluB;
      ALU_OR:  aluRes = idEx.rdat1 | aluB;
      ALU_SLT: aluRes = {31'b0, $signed(idEx.rdat1) < $signed(aluB)};
      ALU_LUI: aluRes = {aluB[15:0], 16'h0};
      default: aluRes = '0;
    endcase
  end

  // Branches compare registers directly, target is relative to the next PC
  assign branchTarget = idEx.pc + 32'd4 + {idEx.imm[29:0], 2'b00};
  assign taken        = idEx.ctrl.branch && ((idEx.rdat1 == idEx.rdat2) != idEx.ctrl.bne);

  assign redirect = '{valid: active && (idEx.ctrl.jump || taken),
                      target: idEx.ctrl.jump ? idEx.jumpTarget : branchTarget};

  assign isMem     = active && (idEx.ctrl.memRead || idEx.ctrl.memWrite);
  assign dReqValid = isMem;
  assign dReq      = '{write: idEx.ctrl.memWrite, addr: aluRes, wdata: idEx.rdat2};
  assign exStall   = isMem && !dReqReady;  // Holds ID/EX so dReq stays steady

  assign exDest   = idEx.dest;
  assign exWrites = active && idEx.ctrl.regWrite;

  // Register file takes this at the retire edge
  assign wb = '{valid: exWrites && !exStall, dest: idEx.dest,
                data: idEx.ctrl.memRead ? dRdata : aluRes};

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      halted <= 1'b0;
    else if (active && idEx.ctrl.halt)
      halted <= 1'b1;  // Sticky until reset
  end

endmodule

//--- rtl/memArbiter.sv
// One access in flight; data beats fetch when both ask, grant held until the handshake
`timescale 1ns/1ps

module memArbiter
  import cpuTypesPkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    iReqValid,
  input  word_t   iReqAddr,
  output logic    iReqReady,
  output word_t   iRdata,
  input  logic    dReqValid,
  input  memReq_t dReq,
  output logic    dReqReady,
  output word_t   dRdata,
  output logic    memValid,
  output memReq_t memReq,
  input  logic    memReady,
  input  word_t   memRdata
);

  typedef enum logic [1:0] {
    IDLE,
    GRANT_I,
    GRANT_D
  } arbState_t;

  arbState_t state;
  logic      grantD;
  logic      grantI;

  // Grant in IDLE is combinational so an idle port costs no cycle
  assign grantD = (state == GRANT_D) || (state == IDLE && dReqValid);
  assign grantI = (state == GRANT_I) || (state == IDLE && !dReqValid && iReqValid);

  assign memValid = (grantD && dReqValid) || (grantI && iReqValid);
  assign memReq   = grantD ? dReq : '{write: 1'b0, addr: iReqAddr, wdata: '0};

  assign dReqReady = grantD && memReady;
  assign iReqReady = grantI && memReady;
  assign dRdata    = grantD ? memRdata : '0;
  assign iRdata    = grantI ? memRdata : '0;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else if (memValid && !memReady)
      state <= grantD ? GRANT_D : GRANT_I;  // Lock while waiting
    else
      state <= IDLE;
  end

endmodule

//--- rtl/pipelineCpu.sv
// Memory is external and must answer reads combinationally with memReady
`timescale 1ns/1ps

module pipelineCpu
  import cpuTypesPkg::*;
#(
  parameter word_t RESET_PC = '0
)
(
  input  logic    CLK,
  input  logic    nRST,
  output logic    memValid,
  output memReq_t memReq,
  input  logic    memReady,
  input  word_t   memRdata,
  output logic    halted
);

  ifId_t     fetched;
  ifId_t     ifId;
  idEx_t     idEx;
  wb_t       wb;
  redirect_t redirect;
  memReq_t   dReq;
  regBits_t  exDest;
  word_t     iReqAddr;
  word_t     iRdata;
  word_t     dRdata;
  logic      takeIn;
  logic      exStall;
  logic      exWrites;
  logic      iReqValid;
  logic      iReqReady;
  logic      dReqValid;
  logic      dReqReady;

  fetchUnit #(.RESET_PC(RESET_PC)) fetch0 (
    .CLK(CLK), .nRST(nRST), .halted(halted), .slotFree(takeIn), .redirect(redirect),
    .iReqValid(iReqValid), .iReqAddr(iReqAddr), .iReqReady(iReqReady), .iRdata(iRdata),
    .fetched(fetched)
  );

  pipeRegIfId ifIdReg0 (
    .CLK(CLK), .nRST(nRST), .enable(takeIn), .flush(redirect.valid),
    .ifIdIn(fetched), .ifIdOut(ifId)
  );

  decodeStage decode0 (
    .CLK(CLK), .nRST(nRST), .ifId(ifId), .wb(wb), .exStall(exStall), .redirect(redirect),
    .exDest(exDest), .exWrites(exWrites), .takeIn(takeIn), .idEx(idEx)
  );

  executeStage execute0 (
    .CLK(CLK), .nRST(nRST), .idEx(idEx), .exStall(exStall), .exDest(exDest),
    .exWrites(exWrites), .redirect(redirect), .wb(wb), .dReqValid(dReqValid), .dReq(dReq),
    .dReqReady(dReqReady), .dRdata(dRdata), .halted(halted)
  );

  memArbiter arbiter0 (
    .CLK(CLK), .nRST(nRST),
    .iReqValid(iReqValid), .iReqAddr(iReqAddr), .iReqReady(iReqReady), .iRdata(iRdata),
    .dReqValid(dReqValid), .dReq(dReq), .dReqReady(dReqReady), .dRdata(dRdata),
    .memValid(memValid), .memReq(memReq), .memReady(memReady), .memRdata(memRdata)
  );

endmodule

//--- verification/pipelineCpu_assert.sv
// Bound into pipelineCpu; the flush check assumes a branch or jump never stalls in execute
`timescale 1ns/1ps

module pipelineCpu_assert
  import cpuTypesPkg::*;
(
  input logic      CLK,
  input logic      nRST,
  input logic      memValid,
  input memReq_t   memReq,
  input logic      memReady,
  input logic      halted,
  input redirect_t redirect,
  input ifId_t     ifId,
  input idEx_t     idEx
);

  int errorCount = 0;

  // Waiting request keeps its address and data
  reqHeld: assert property (@(posedge CLK) disable iff (!nRST)
    memValid && !memReady |=> memValid && $stable(memReq))
  else
  begin
    errorCount++;
    $error("memory request changed before its handshake");
  end

  idleInReset: assert property (@(posedge CLK) !nRST |-> !memValid)
  else
  begin
    errorCount++;
    $error("memValid high during reset");
  end

  haltSticky: assert property (@(posedge CLK) disable iff (!nRST) halted |=> halted)
  else
  begin
    errorCount++;
    $error("halted fell without a reset");
  end

  // Both wrong-path slots reach execute as bubbles
  flushClears: assert property (@(posedge CLK) disable iff (!nRST)
    redirect.valid |=> (!ifId.valid && !idEx.valid) ##1 !idEx.valid)
  else
  begin
    errorCount++;
    $error("wrong-path instruction reached execute after a redirect");
  end

endmodule

bind pipelineCpu pipelineCpu_assert assert0 (
  .CLK(CLK), .nRST(nRST), .memValid(memValid), .memReq(memReq), .memReady(memReady),
  .halted(halted), .redirect(redirect), .ifId(ifId), .idEx(idEx)
);

//--- verification/pipelineCpuTb.sv
// Memory model decodes address bits 9:2 only; program and expected stores come from testdata
`timescale 1ns/1ps

module pipelineCpuTb
  import cpuTypesPkg::*;
();

  localparam word_t RESET_PC     = 32'h1000_0000;  // Aliases to word 0 of the model
  localparam int    MEM_WORDS    = 256;
  localparam int    QUIET_CYCLES = 16;

  logic    CLK = 1'b0;
  logic    nRST;
  logic    memValid;
  memReq_t memReq;
  logic    memReady = 1'b0;
  word_t   memRdata;
  logic    halted;

  word_t      testData [512];  // Image in 0..255, store count at 256, pairs from 257
  word_t      mem [MEM_WORDS];
  word_t      expCount;
  word_t      storeCount = '0;
  logic [8:0] expIdx;
  logic       readyNext;
  logic       haltSeen = 1'b0;
  int         idx;
  int         progWords;
  int         cycleLimit;
  int         cycles = 0;
  int         storeErrors = 0;
  int         haltErrors = 0;
  int         signalErrors = 0;

  pipelineCpu #(.RESET_PC(RESET_PC)) dut0 (
    .CLK(CLK), .nRST(nRST), .memValid(memValid), .memReq(memReq),
    .memReady(memReady), .memRdata(memRdata), .halted(halted)
  );

  assign memRdata = mem[memReq.addr[9:2]];

  always #4 CLK = ~CLK;

  task automatic checkStore(input memReq_t got, input word_t expAddr, input word_t expData,
                            input word_t index);
    if (got.addr !== expAddr || got.wdata !== expData)
    begin
      storeErrors++;
      $display("CHECK FAILED @%0t: store %0d wrote %h to %h, expected %h to %h",
               $time, index, got.wdata, got.addr, expData, expAddr);
    end
  endtask

  task automatic checkHalt(input word_t gotCount, input word_t wantCount);
    if (gotCount !== wantCount)
    begin
      haltErrors++;
      $display("CHECK FAILED @%0t: %0d stores seen at halt, expected %0d",
               $time, gotCount, wantCount);
    end
  endtask

  task automatic expectLevel(input logic value, input logic want, input string what);
    if (value !== want)
    begin
      signalErrors++;
      $display("CHECK FAILED @%0t: %s is %b, expected %b", $time, what, value, want);
    end
  endtask

  task automatic compareFetchAddr(input memReq_t got);
    if (got.write !== 1'b0 || got.addr !== RESET_PC)
    begin
      signalErrors++;
      $display("CHECK FAILED @%0t: first request write %b addr %h, expected a read of %h",
               $time, got.write, got.addr, RESET_PC);
    end
  endtask

  // Memory model and store monitor; a transfer is decided here for the next rising edge
  always @(negedge CLK)
  begin
    readyNext = ($urandom % 4) != 0;  // Ready about three cycles in four
    memReady  = readyNext;
    if (halted === 1'b1 && !haltSeen)
    begin
      haltSeen = 1'b1;
      checkHalt(storeCount, expCount);
    end
    if (memValid === 1'b1 && readyNext && memReq.write === 1'b1)
    begin
      mem[memReq.addr[9:2]] = memReq.wdata;
      if (haltSeen || storeCount >= expCount)
      begin
        storeErrors++;
        $display("CHECK FAILED @%0t: unexpected store of %h to %h",
                 $time, memReq.wdata, memReq.addr);
      end
      else
      begin
        expIdx = 9'd257 + {storeCount[7:0], 1'b0};
        checkStore(memReq, testData[expIdx], testData[expIdx + 9'd1], storeCount);
      end
      storeCount++;
    end
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    nRST = 1'b0;
    void'($urandom(32'h52bd_41d2));
    for (idx = 0; idx < 512; idx++)
      testData[idx[8:0]] = 32'hA5A5_0000 | idx;  // Fill decodes as a NOP
    $readmemh("verification/cpu_testdata.mem", testData);
    for (idx = 0; idx < MEM_WORDS; idx++)
      mem[idx[7:0]] = testData[idx[8:0]];
    expCount  = testData[9'd256];
    progWords = MEM_WORDS;
    for (idx = MEM_WORDS - 1; idx >= 0; idx--)
      if (testData[idx[8:0]][31:26] == OP_HALT)
        progWords = idx + 1;
    cycleLimit = progWords * 40 * 4;

    repeat (4)
    begin
      @(negedge CLK);
      expectLevel(memValid, 1'b0, "memValid in reset");
      expectLevel(halted, 1'b0, "halted in reset");
    end
    nRST = 1'b1;

    @(negedge CLK);
    while (memValid !== 1'b1)
    begin
      expectLevel(halted, 1'b0, "halted before first fetch");
      @(negedge CLK);
    end
    compareFetchAddr(memReq);

    wait (haltSeen);
    while (memValid === 1'b1)  // Fetch in flight at the halt may still finish
      @(negedge CLK);
    repeat (QUIET_CYCLES)
    begin
      @(negedge CLK);
      expectLevel(memValid, 1'b0, "memValid after halt");
      expectLevel(halted, 1'b1, "halted after halt");
    end

    $display("Errors: store %0d, halt %0d, signal %0d, assertion %0d",
             storeErrors, haltErrors, signalErrors, dut0.assert0.errorCount);
    if (storeErrors + haltErrors + signalErrors + dut0.assert0.errorCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verification/cpu_testdata.mem
// Words 000-0FF: program image at byte address 0, one instruction per line
// Word 100: expected store count; from 101: expected store address, then store data
@000
24010005 // ADDIU $1, $0, 5
24020007 // ADDIU $2, $0, 7
00221821 // ADDU  $3, $1, $2      -> 12
AC030200 // SW    $3, 0x200       back-to-back use
00222023 // SUBU  $4, $1, $2      -> -2
AC040204 // SW    $4, 0x204
00622824 // AND   $5, $3, $2      -> 4
00613025 // OR    $6, $3, $1      -> 13
0081382A // SLT   $7, $4, $1      -> 1
AC050208 // SW    $5, 0x208
AC06020C // SW    $6, 0x20C
AC070210 // SW    $7, 0x210
3C081234 // LUI   $8, 0x1234
35085678 // ORI   $8, $8, 0x5678  -> 12345678
AC080214 // SW    $8, 0x214
8C090214 // LW    $9, 0x214
25290001 // ADDIU $9, $9, 1       load-use
AC090218 // SW    $9, 0x218
10220001 // BEQ   $1, $2, +1      not taken
AC01021C // SW    $1, 0x21C       fall-through
14220002 // BNE   $1, $2, +2      taken to 0x5C
AC0202F0 // SW    $2, 0x2F0       wrong path
AC0202F4 // SW    $2, 0x2F4       wrong path
10630002 // BEQ   $3, $3, +2      taken to 0x68
AC0302F8 // SW    $3, 0x2F8       wrong path
AC0302FC // SW    $3, 0x2FC       wrong path
0800001E // J     0x78
AC0402E0 // SW    $4, 0x2E0       wrong path
AC0402E4 // SW    $4, 0x2E4       wrong path
AC0502E8 // SW    $5, 0x2E8       skipped by J
AC060220 // SW    $6, 0x220
FC000000 // HALT
AC0102EC // SW    $1, 0x2EC       after HALT
@100
00000009
00000200 0000000C
00000204 FFFFFFFE
00000208 00000004
0000020C 0000000D
00000210 00000001
00000214 12345678
00000218 12345679
0000021C 00000005
00000220 0000000D

//--- vlog.f
rtl/cpuTypesPkg.sv
rtl/pipeRegIfId.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memArbiter.sv
rtl/pipelineCpu.sv
verification/pipelineCpu_assert.sv
verification/pipelineCpuTb.sv

//--- Makefile
# Verilator build and run of the pipelined CPU testbench
TOP := pipelineCpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run; fails unless the pass line is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
